/* verilog.f */
+incdir+include
design/x68k_glue_pkg.sv
design/clock_enable_gen.sv
design/media_reset_ctrl.sv
design/loader_bridge.sv
design/synth_bridge.sv
design/x68k_glue_top.sv
sim/tb_x68k_glue.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_x68k_glue
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/tb_ref.svh */
// Reference models of the X68000 glue rules and the value compare used by the testbench
`ifndef TB_REF_SVH
`define TB_REF_SVH

// Pulses of an enable with the given period over a whole number of periods
function automatic int expected_pulses(input int cycles, input int period);
	return cycles / period;
endfunction

// Floppy window from negedges since the mount and eject pulses, as {mounted, eject}
// The output register shows the count one cycle behind the load
function automatic logic [1:0] floppy_window(input int mount_age, input int eject_age);
	int   mount_left;
	int   eject_left;
	logic ejecting;
	mount_left = (mount_age <= 0) ? 0 : MOUNT_HOLD_TB - mount_age + 1;
	eject_left = (eject_age <= 0) ? 0 : EJECT_HOLD_TB - eject_age + 1;
	if (mount_left < 0)
		mount_left = 0;
	if (eject_left < 0)
		eject_left = 0;
	ejecting = (mount_left >= EJECT_HOLD_TB) || (eject_left > 0);
	return {(mount_left > 0) && !ejecting, ejecting};
endfunction

function automatic logic [3:0] info_index_model(input logic [7:0] mode, input logic [1:0] rom,
		input logic [2:0] sf);
	if (mode == SYNTH_MODE_FLUID)
		return 4'(sf) + 4'd1;
	if (mode != SYNTH_MODE_MUNT)
		return INFO_UNKNOWN;
	case (rom)
		2'd0: return 4'd9;
		2'd1: return 4'd10;
		2'd2: return 4'd11;
		default: return INFO_UNKNOWN;
	endcase
endfunction

// MIDI line stays idle high while an attached synth is switched off
function automatic logic midi_line_model(input logic available, input logic disabled,
		input logic tx);
	if (available && disabled)
		return 1'b1;
	return tx;
endfunction

// Per channel sum modulo 2^16
function automatic stereo_t wrapped_sum(input stereo_t a, input stereo_t b);
	stereo_t s;
	int      l;
	int      r;
	l = int'(a.left) + int'(b.left);
	r = int'(a.right) + int'(b.right);
	s.left  = 16'(l % 65536);
	s.right = 16'(r % 65536);
	return s;
endfunction

task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	check_count++;
	if (expected !== actual) begin
		error_count++;
		$display("Fail at time %0t: %s expected 0x%0h, actual 0x%0h", $time, name, expected,
			actual);
	end
endtask

task automatic note_failure(input string what);
	error_count++;
	$display("Error at time %0t: %s", $time, what);
endtask

`endif

/* sim/tb_x68k_glue.sv */
// Testbench for the X68000 system glue covering enables, media, reset, loader and synth
`timescale 1ns/100ps

module tb_x68k_glue
	import x68k_glue_pkg::*;
();

	localparam int CLK_PERIOD        = 10;
	localparam int RESET_CYCLES      = 16;
	localparam int MOUNT_HOLD_TB     = 300;
	localparam int EJECT_HOLD_TB     = 100;
	localparam int HDD_RESET_HOLD_TB = 50;
	localparam int LED_HOLD_TB       = 40;
	localparam int ENABLE_SETTLE     = 40;
	localparam int ENABLE_WINDOW     = 200;
	localparam int MEDIA_CYCLES      = MOUNT_HOLD_TB + 30;
	localparam int WRITE_COUNT       = 20;
	localparam int SYNTH_TRIALS      = 40;
	localparam int INFO_WINDOW       = 6;
	localparam int AUDIO_TRIALS      = 60;
	// All test lengths added up, plus a margin
	localparam int RUN_CYCLES = RESET_CYCLES + 4 * (ENABLE_SETTLE + ENABLE_WINDOW)
		+ MEDIA_CYCLES + HDD_RESET_HOLD_TB + LED_HOLD_TB + 80 + WRITE_COUNT * 10
		+ SYNTH_TRIALS + 2 * (INFO_WINDOW + 2) + AUDIO_TRIALS + 200;

	logic          clk_sys = 1'b0;
	logic          reset_delayed;
	menu_cmd_t     menu;
	logic          user_button;
	logic          snd_clockmode;
	logic [3:0]    img_mounted;
	logic          hdd_ack;
	loader_req_t   host_ldr;
	logic          ldr_ack;
	synth_status_t synth;
	logic          uart_tx;
	stereo_t       core_audio;
	stereo_t       synth_audio;
	clk_en_t       clk_en;
	media_state_t  media;
	logic          core_run;
	logic          hdd_led;
	loader_ctl_t   ldr;
	logic          info_req;
	logic [3:0]    info_index;
	logic          midi_tx;
	stereo_t       audio;

	int         seed;
	int         check_count;
	int         error_count;
	int         errors_at_start;
	int         wr_rises;
	logic       wr_prev = 1'b0;
	logic       exp_valid = 1'b0;
	logic [3:0] exp_index;
	stereo_t    exp_audio;

	`include "tb_ref.svh"

	x68k_glue_top #(
		.MOUNT_HOLD     (MOUNT_HOLD_TB),
		.EJECT_HOLD     (EJECT_HOLD_TB),
		.HDD_RESET_HOLD (HDD_RESET_HOLD_TB),
		.LED_HOLD       (LED_HOLD_TB)
	) DUT (
		.clk_sys (clk_sys), .reset_delayed (reset_delayed), .menu (menu),
		.user_button (user_button), .snd_clockmode (snd_clockmode),
		.img_mounted (img_mounted), .hdd_ack (hdd_ack), .host_ldr (host_ldr),
		.ldr_ack (ldr_ack), .synth (synth), .uart_tx (uart_tx), .core_audio (core_audio),
		.synth_audio (synth_audio), .clk_en (clk_en), .media (media), .core_run (core_run),
		.hdd_led (hdd_led), .ldr (ldr), .info_req (info_req), .info_index (info_index),
		.midi_tx (midi_tx), .audio (audio)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	//////////////////////////////////////////////////////////////////////
	// Comparing process
	//////////////////////////////////////////////////////////////////////
	// Registered outputs follow the inputs seen at each rising edge
	always @(posedge clk_sys) begin
		exp_valid <= !reset_delayed;
		exp_index <= info_index_model(synth.mode, synth.rom, synth.sf);
		exp_audio <= wrapped_sum(core_audio, synth_audio);
	end

	always @(negedge clk_sys) begin
		if (exp_valid) begin
			compare_value("info_index", exp_index, info_index);
			compare_value("audio", exp_audio, audio);
			compare_value("mpu_cep and mpu_cen together", 0, clk_en.mpu_cep & clk_en.mpu_cen);
			if (ldr.wr && !wr_prev)
				wr_rises++;
		end
		wr_prev = ldr.wr;
	end

	initial begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("Timeout, the tests did not finish within %0d cycles", RUN_CYCLES);
		$display("Verification failed");
		$finish;
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic close_test(input string name);
		$display("Test %s finished with %0d errors", name, error_count - errors_at_start);
		errors_at_start = error_count;
	endtask

	task automatic await_core_run(input int limit);
		int waited;
		waited = 0;
		while (core_run !== 1'b1 && waited < limit) begin
			@(negedge clk_sys);
			waited++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////
	task automatic count_enable_pulses(input logic turbo_mode, input logic slow_snd);
		int n_sys;
		int n_cep;
		int n_cen;
		int n_snd;
		int n_opm0;
		int n_opm1;
		int last_cep;
		menu.turbo    = turbo_mode;
		snd_clockmode = slow_snd;
		wait_cycles(ENABLE_SETTLE);
		{n_sys, n_cep, n_cen, n_snd, n_opm0, n_opm1} = '0;
		last_cep = -1;
		for (int c = 0; c < ENABLE_WINDOW; c++) begin
			@(negedge clk_sys);
			n_sys  += clk_en.sys_ce;
			n_cep  += clk_en.mpu_cep;
			n_cen  += clk_en.mpu_cen;
			n_snd  += clk_en.snd_ce;
			n_opm0 += clk_en.opm_ce[0];
			n_opm1 += clk_en.opm_ce[1];
			if (turbo_mode)
				compare_value("mpu_cep xor mpu_cen", 1, clk_en.mpu_cep ^ clk_en.mpu_cen);
			else if (clk_en.mpu_cen && last_cep >= 0)
				compare_value("mpu_cen offset from mpu_cep", 2, c - last_cep);
			if (clk_en.mpu_cep)
				last_cep = c;
		end
		compare_value("sys_ce count", expected_pulses(ENABLE_WINDOW, SYS_DIV), n_sys);
		// Turbo phases alternate, a period of 2
		compare_value("mpu_cep count", expected_pulses(ENABLE_WINDOW, turbo_mode ? 2 : SYS_DIV),
			n_cep);
		compare_value("mpu_cen count", expected_pulses(ENABLE_WINDOW, turbo_mode ? 2 : SYS_DIV),
			n_cen);
		compare_value("snd_ce count", expected_pulses(ENABLE_WINDOW,
			slow_snd ? SND_DIV_SLOW : SND_DIV_FAST), n_snd);
		compare_value("opm_ce[0] count", expected_pulses(ENABLE_WINDOW, SND_DIV_SLOW), n_opm0);
		compare_value("opm_ce[1] count", expected_pulses(ENABLE_WINDOW, OPM_DIV), n_opm1);
	endtask

	task automatic follow_media_windows();
		int         eject_delay;
		logic [1:0] w_before;
		logic [1:0] w_now;
		logic [1:0] w_after;
		eject_delay = 20 + {$random(seed)} % 128;
		for (int c = 0; c < MEDIA_CYCLES; c++) begin
			@(negedge clk_sys);
			img_mounted[0]   = (c == 0);
			menu.fd_eject[1] = (c == eject_delay);
			// Skip samples within one cycle of a window edge
			w_before = floppy_window(c - 1, 0);
			w_now    = floppy_window(c, 0);
			w_after  = floppy_window(c + 1, 0);
			if (w_before == w_now && w_now == w_after) begin
				compare_value("media.mounted[0]", w_now[1], media.mounted[0]);
				compare_value("media.fd_eject[0]", w_now[0], media.fd_eject[0]);
			end
			w_before = floppy_window(0, c - eject_delay - 1);
			w_now    = floppy_window(0, c - eject_delay);
			w_after  = floppy_window(0, c - eject_delay + 1);
			if (w_before == w_now && w_now == w_after) begin
				compare_value("media.mounted[1]", w_now[1], media.mounted[1]);
				compare_value("media.fd_eject[1]", w_now[0], media.fd_eject[1]);
			end
			compare_value("media.mounted[3:2]", 0, media.mounted[3:2]);
		end
	endtask

	task automatic sequence_core_reset();
		int waited;
		for (int c = 0; c < 20; c++) begin
			@(negedge clk_sys);
			compare_value("core_run before download", 0, core_run);
		end
		host_ldr.download = 1'b1;
		await_core_run(6);
		compare_value("core_run after download start", 1, core_run);

		img_mounted[HDD_INDEX] = 1'b1;
		wait_cycles(1);
		img_mounted[HDD_INDEX] = 1'b0;
		// The stretch count loads first and core_run drops a cycle later
		wait_cycles(1);
		compare_value("core_run after hard disk mount", 0, core_run);
		compare_value("media.mounted[2] after hard disk mount", 1, media.mounted[HDD_INDEX]);
		waited = 2;
		while (core_run !== 1'b1 && waited < HDD_RESET_HOLD_TB + 2) begin
			@(negedge clk_sys);
			waited++;
		end
		compare_value("core_run after reset stretch", 1, core_run);
		if (waited < HDD_RESET_HOLD_TB)
			note_failure("core_run came back before the reset stretch ran out");

		menu.reset_req = 1'b1;
		wait_cycles(2);
		compare_value("core_run under menu reset", 0, core_run);
		menu.reset_req = 1'b0;
		await_core_run(3);
		compare_value("core_run after menu reset", 1, core_run);
		user_button = 1'b1;
		wait_cycles(2);
		compare_value("core_run under user button", 0, core_run);
		user_button = 1'b0;
		await_core_run(3);
		compare_value("core_run after user button", 1, core_run);

		hdd_ack = 1'b1;
		wait_cycles(1);
		hdd_ack = 1'b0;
		waited = 1;
		while (hdd_led !== 1'b1 && waited < 3) begin
			@(negedge clk_sys);
			waited++;
		end
		compare_value("hdd_led after hdd_ack", 1, hdd_led);
		while (hdd_led !== 1'b0 && waited < LED_HOLD_TB + 2) begin
			@(negedge clk_sys);
			waited++;
		end
		compare_value("hdd_led after stretch", 0, hdd_led);
		if (waited < LED_HOLD_TB)
			note_failure("hdd_led went out before the LED stretch ran out");
	endtask

	task automatic stream_loader_writes();
		int delay;
		wr_rises = 0;
		compare_value("ldr.aen during download", 1, ldr.aen);
		for (int i = 0; i < WRITE_COUNT; i++) begin
			host_ldr.wr = 1'b1;
			wait_cycles(1);
			host_ldr.wr = 1'b0;
			compare_value("ldr.wr after host write", 1, ldr.wr);
			delay = 1 + {$random(seed)} % 5;
			wait_cycles(delay);
			ldr_ack = 1'b1;
			wait_cycles(1);
			ldr_ack = 1'b0;
			compare_value("ldr.wr after ldr_ack", 0, ldr.wr);
		end
		host_ldr.download = 1'b0;
		wait_cycles(1);
		compare_value("ldr.done after download", 1, ldr.done);
		compare_value("ldr.aen after download", 0, ldr.aen);
		compare_value("ldr.wr rising edges", WRITE_COUNT, wr_rises);
	endtask

	task automatic exercise_synth_bridge();
		int pick;
		int pulses;
		for (int i = 0; i < SYNTH_TRIALS; i++) begin
			@(negedge clk_sys);
			pick = {$random(seed)} % 3;
			synth.mode = (pick == 0) ? SYNTH_MODE_FLUID
			           : (pick == 1) ? SYNTH_MODE_MUNT : 8'($random(seed));
			synth.rom       = 2'($random(seed));
			synth.sf        = 3'($random(seed));
			synth.available = 1'($random(seed));
			synth.disabled  = 1'($random(seed));
			uart_tx         = 1'($random(seed));
			#1;
			compare_value("midi_tx", midi_line_model(synth.available, synth.disabled, uart_tx),
				midi_tx);
		end
		for (int m = 1; m >= 0; m--) begin
			synth.info_mode = 2'(m);
			wait_cycles(2);
			synth.newmode = ~synth.newmode;
			pulses = 0;
			for (int c = 0; c < INFO_WINDOW; c++) begin
				@(negedge clk_sys);
				pulses += info_req;
			end
			compare_value(m ? "info_req pulses, info_mode 1" : "info_req pulses, info_mode 0",
				m, pulses);
		end
	endtask

	task automatic drive_audio_pairs();
		for (int i = 0; i < AUDIO_TRIALS; i++) begin
			@(negedge clk_sys);
			core_audio  = $random(seed);
			synth_audio = $random(seed);
		end
		wait_cycles(2);
	endtask

	initial begin
		seed            = 71;
		check_count     = 0;
		error_count     = 0;
		errors_at_start = 0;
		reset_delayed   = 1'b1;
		menu            = '0;
		user_button     = 1'b0;
		snd_clockmode   = 1'b0;
		img_mounted     = '0;
		hdd_ack         = 1'b0;
		host_ldr        = '0;
		ldr_ack         = 1'b0;
		synth           = '0;
		uart_tx         = 1'b1;
		core_audio      = '0;
		synth_audio     = '0;
		wait_cycles(RESET_CYCLES);
		reset_delayed = 1'b0;

		for (int mode = 0; mode < 4; mode++)
			count_enable_pulses(mode[1], mode[0]);
		close_test("clock enables");
		follow_media_windows();
		close_test("media windows");
		sequence_core_reset();
		close_test("reset sequencing");
		stream_loader_writes();
		close_test("loader bridge");
		exercise_synth_bridge();
		close_test("synth bridge");
		drive_audio_pairs();
		close_test("audio");

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* design/x68k_glue_top.sv */
// X68000 system glue top level joining clock enables, media sequencing, loader and synth
`timescale 1ns/100ps

module x68k_glue_top
	import x68k_glue_pkg::*;
#(
	parameter int MOUNT_HOLD     = MOUNT_HOLD_DEFAULT,
	parameter int EJECT_HOLD     = EJECT_HOLD_DEFAULT,
	parameter int HDD_RESET_HOLD = HDD_RESET_HOLD_DEFAULT,
	parameter int LED_HOLD       = LED_HOLD_DEFAULT
) (
	input  logic          clk_sys,
	input  logic          reset_delayed,
	input  menu_cmd_t     menu,
	input  logic          user_button,
	input  logic          snd_clockmode,
	input  logic [3:0]    img_mounted,
	input  logic          hdd_ack,
	input  loader_req_t   host_ldr,
	input  logic          ldr_ack,
	input  synth_status_t synth,
	input  logic          uart_tx,
	input  stereo_t       core_audio,
	input  stereo_t       synth_audio,
	output clk_en_t       clk_en,
	output media_state_t  media,
	output logic          core_run,
	output logic          hdd_led,
	output loader_ctl_t   ldr,
	output logic          info_req,
	output logic [3:0]    info_index,
	output logic          midi_tx,
	output stereo_t       audio
);

	logic download_start;

	clock_enable_gen u_clock_enable_gen (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.turbo         (menu.turbo),
		.snd_clockmode (snd_clockmode),
		.clk_en        (clk_en)
	);

	media_reset_ctrl #(
		.MOUNT_HOLD     (MOUNT_HOLD),
		.EJECT_HOLD     (EJECT_HOLD),
		.HDD_RESET_HOLD (HDD_RESET_HOLD),
		.LED_HOLD       (LED_HOLD)
	) u_media_reset_ctrl (
		.clk_sys        (clk_sys),
		.reset_delayed  (reset_delayed),
		.menu           (menu),
		.user_button    (user_button),
		.img_mounted    (img_mounted),
		.hdd_ack        (hdd_ack),
		.download_start (download_start),
		.media          (media),
		.core_run       (core_run),
		.hdd_led        (hdd_led)
	);

	loader_bridge u_loader_bridge (
		.clk_sys        (clk_sys),
		.reset_delayed  (reset_delayed),
		.host_ldr       (host_ldr),
		.ldr_ack        (ldr_ack),
		.ldr            (ldr),
		.download_start (download_start)
	);

	synth_bridge u_synth_bridge (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.synth         (synth),
		.uart_tx       (uart_tx),
		.core_audio    (core_audio),
		.synth_audio   (synth_audio),
		.info_req      (info_req),
		.info_index    (info_index),
		.midi_tx       (midi_tx),
		.audio         (audio)
	);

endmodule

/* design/synth_bridge.sv */
// MIDI synth attachment with info request, info index, MIDI mute and audio summing
`timescale 1ns/100ps

module synth_bridge
	import x68k_glue_pkg::*;
(
	input  logic          clk_sys,
	input  logic          reset_delayed,
	input  synth_status_t synth,
	input  logic          uart_tx,
	input  stereo_t       core_audio,
	input  stereo_t       synth_audio,
	output logic          info_req,
	output logic [3:0]    info_index,
	output logic          midi_tx,
	output stereo_t       audio
);

	logic       newmode_s;
	logic       newmode_q;
	logic       synth_mute;
	logic [3:0] index_next;

	// Silence the MIDI line when the synth is present but switched off
	assign synth_mute = synth.available && synth.disabled;
	assign midi_tx    = uart_tx | synth_mute;

	//////////////////////////////////////////////////////////////////////
	// Info screen selection
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		if (synth.mode == SYNTH_MODE_FLUID)
			index_next = 4'd1 + {1'b0, synth.sf};
		else if (synth.mode == SYNTH_MODE_MUNT && synth.rom != 2'd3)
			// MT-32 v1, MT-32 v2, CM-32L
			index_next = 4'd9 + {2'b00, synth.rom};
		else
			index_next = INFO_UNKNOWN;
	end

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			newmode_s  <= 1'b0;
			newmode_q  <= 1'b0;
			info_req   <= 1'b0;
			info_index <= '0;
			audio      <= '0;
		end else begin
			// newmode toggles once per mode change from the synth
			newmode_s  <= synth.newmode;
			newmode_q  <= newmode_s;
			info_req   <= (newmode_s ^ newmode_q) && (synth.info_mode == 2'd1);
			info_index <= index_next;

			// Plain wrapping sum per channel
			audio.left  <= core_audio.left + synth_audio.left;
			audio.right <= core_audio.right + synth_audio.right;
		end
	end

endmodule

/* design/loader_bridge.sv */
// Loader bridge from host download strobes to the held core write request
`timescale 1ns/100ps

module loader_bridge
	import x68k_glue_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset_delayed,
	input  loader_req_t host_ldr,
	input  logic        ldr_ack,
	output loader_ctl_t ldr,
	output logic        download_start
);

	logic download_q;
	logic ack_q;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			download_q     <= 1'b0;
			ack_q          <= 1'b0;
			download_start <= 1'b0;
			ldr            <= '0;
		end else begin
			download_q     <= host_ldr.download;
			ack_q          <= ldr_ack;
			download_start <= host_ldr.download && !download_q;

			// A new strobe wins over an acknowledge in the same cycle
			if (ldr_ack && !ack_q && ldr.wr)
				ldr.wr <= 1'b0;
			if (host_ldr.wr && !ldr.done)
				ldr.wr <= 1'b1;

			if (download_q && !host_ldr.download)
				ldr.done <= 1'b1;
			ldr.aen <= host_ldr.download && !ldr.done;
		end
	end

	// After done, the core sees no further writes
	a_no_wr_after_done: assert property (@(posedge clk_sys) disable iff (reset_delayed)
		$rose(ldr.wr) |-> !$past(ldr.done));

endmodule

/* design/media_reset_ctrl.sv */
// Media mount and eject windows, core reset sequencing and hard disk activity LED
`timescale 1ns/100ps

module media_reset_ctrl
	import x68k_glue_pkg::*;
#(
	parameter int MOUNT_HOLD     = MOUNT_HOLD_DEFAULT,
	parameter int EJECT_HOLD     = EJECT_HOLD_DEFAULT,
	parameter int HDD_RESET_HOLD = HDD_RESET_HOLD_DEFAULT,
	parameter int LED_HOLD       = LED_HOLD_DEFAULT
) (
	input  logic         clk_sys,
	input  logic         reset_delayed,
	input  menu_cmd_t    menu,
	input  logic         user_button,
	input  logic [3:0]   img_mounted,
	input  logic         hdd_ack,
	input  logic         download_start,
	output media_state_t media,
	output logic         core_run,
	output logic         hdd_led
);

	localparam int MOUNT_W   = $clog2(MOUNT_HOLD + 1);
	localparam int EJECT_W   = $clog2(EJECT_HOLD + 1);
	localparam int STRETCH_W = $clog2(HDD_RESET_HOLD + 1);
	localparam int LED_W     = $clog2(LED_HOLD + 1);

	logic [MOUNT_W-1:0]   mount_cnt [DRIVE_COUNT];
	logic [EJECT_W-1:0]   eject_cnt [FDD_COUNT];
	logic [STRETCH_W-1:0] stretch_cnt;
	logic [LED_W-1:0]     led_cnt;
	logic                 hdd_mount_q;
	logic                 boot_seen;
	media_state_t         media_next;

	//////////////////////////////////////////////////////////////////////
	// Window decode
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		media_next = '0;
		for (int d = 0; d < DRIVE_COUNT; d++) begin
			if (d < FDD_COUNT) begin
				// Eject phase first, then the mounted phase for the rest of the hold
				media_next.fd_eject[d] = (mount_cnt[d] >= EJECT_HOLD) || (eject_cnt[d] != '0);
				media_next.mounted[d]  = (mount_cnt[d] != '0) && !media_next.fd_eject[d];
			end else begin
				media_next.mounted[d]  = (mount_cnt[d] != '0);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			for (int d = 0; d < DRIVE_COUNT; d++)
				mount_cnt[d] <= '0;
			for (int f = 0; f < FDD_COUNT; f++)
				eject_cnt[f] <= '0;
			stretch_cnt <= '0;
			led_cnt     <= '0;
			hdd_mount_q <= 1'b0;
			boot_seen   <= 1'b0;
			media       <= '0;
			core_run    <= 1'b0;
			hdd_led     <= 1'b0;
		end else begin
			for (int d = 0; d < DRIVE_COUNT; d++) begin
				if (img_mounted[d])
					mount_cnt[d] <= MOUNT_W'(MOUNT_HOLD);
				else if (mount_cnt[d] != '0)
					mount_cnt[d] <= mount_cnt[d] - 1'b1;
			end
			for (int f = 0; f < FDD_COUNT; f++) begin
				if (menu.fd_eject[f])
					eject_cnt[f] <= EJECT_W'(EJECT_HOLD);
				else if (eject_cnt[f] != '0)
					eject_cnt[f] <= eject_cnt[f] - 1'b1;
			end
			media <= media_next;

			// Hold the core in reset while a new hard disk image settles
			hdd_mount_q <= img_mounted[HDD_INDEX];
			if (img_mounted[HDD_INDEX] && !hdd_mount_q)
				stretch_cnt <= STRETCH_W'(HDD_RESET_HOLD);
			else if (stretch_cnt != '0)
				stretch_cnt <= stretch_cnt - 1'b1;

			// No run until the first ROM download has begun
			if (download_start)
				boot_seen <= 1'b1;
			core_run <= boot_seen && !menu.reset_req && !user_button && (stretch_cnt == '0);

			if (hdd_ack)
				led_cnt <= LED_W'(LED_HOLD);
			else if (led_cnt != '0)
				led_cnt <= led_cnt - 1'b1;
			hdd_led <= (led_cnt != '0);
		end
	end

	a_fdd_mount_eject_excl: assert property (@(posedge clk_sys) disable iff (reset_delayed)
		(media.mounted[FDD_COUNT-1:0] & media.fd_eject) == '0);

endmodule

/* design/clock_enable_gen.sv */
// Clock enable generator for the system, CPU phases, sound and FM synth
`timescale 1ns/100ps

module clock_enable_gen
	import x68k_glue_pkg::*;
(
	input  logic    clk_sys,
	input  logic    reset_delayed,
	input  logic    turbo,
	input  logic    snd_clockmode,
	output clk_en_t clk_en
);

	logic [$clog2(SYS_DIV)-1:0]      div_sys;
	logic [$clog2(SND_DIV_SLOW)-1:0] div_snd;
	logic [$clog2(OPM_DIV)-1:0]      div_opm;
	logic                            turbo_q;
	logic                            sys_wrap;
	logic                            snd_wrap;
	logic                            opm_wrap;

	assign sys_wrap = (div_sys == SYS_DIV - 1);
	assign opm_wrap = (div_opm == OPM_DIV - 1);
	// A mode change can leave the counter past the fast wrap point
	assign snd_wrap = snd_clockmode ? (div_snd >= SND_DIV_SLOW - 1)
	                                : (div_snd >= SND_DIV_FAST - 1);

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			div_sys <= '0;
			div_snd <= '0;
			div_opm <= '0;
			turbo_q <= 1'b0;
			clk_en  <= '0;
		end else begin
			div_sys <= sys_wrap ? '0 : div_sys + 1'b1;
			div_snd <= snd_wrap ? '0 : div_snd + 1'b1;
			div_opm <= opm_wrap ? '0 : div_opm + 1'b1;

			// Speed only changes on a system cycle boundary
			if (sys_wrap)
				turbo_q <= turbo;

			clk_en.sys_ce <= sys_wrap;
			if (turbo_q) begin
				clk_en.mpu_cep <= div_sys[0];
				clk_en.mpu_cen <= ~div_sys[0];
			end else begin
				clk_en.mpu_cep <= sys_wrap;
				clk_en.mpu_cen <= (div_sys == SYS_DIV / 2 - 1);
			end

			clk_en.snd_ce    <= snd_wrap;
			clk_en.opm_ce[0] <= (div_opm == SND_DIV_SLOW - 1) || opm_wrap;
			clk_en.opm_ce[1] <= opm_wrap;
		end
	end

	// The two CPU phases never overlap, including across a turbo switch
	a_mpu_phase_excl: assert property (@(posedge clk_sys) disable iff (reset_delayed)
		!(clk_en.mpu_cep && clk_en.mpu_cen));

endmodule

/* design/x68k_glue_pkg.sv */
// X68000 glue package with the divider ratios, hold lengths, synth codes and shared bus types
package x68k_glue_pkg;

	//////////////////////////////////////////////////////////////////////
	// Clock enable periods, in clk_sys cycles
	//////////////////////////////////////////////////////////////////////
	localparam int SYS_DIV      = 4;
	localparam int SND_DIV_FAST = 5;
	// Also the period of FM enable 0
	localparam int SND_DIV_SLOW = 10;
	localparam int OPM_DIV      = 20;

	//////////////////////////////////////////////////////////////////////
	// Drives and hold windows
	//////////////////////////////////////////////////////////////////////
	localparam int DRIVE_COUNT = 4;
	localparam int FDD_COUNT   = 2;
	localparam int HDD_INDEX   = 2;

	localparam int MOUNT_HOLD_DEFAULT     = 16777215;
	// Floppy mounted phase and eject request share this length
	localparam int EJECT_HOLD_DEFAULT     = 65536;
	localparam int HDD_RESET_HOLD_DEFAULT = 65535;
	localparam int LED_HOLD_DEFAULT       = 4500000;

	// MT32-pi mode codes and the index shown for anything else
	localparam logic [7:0] SYNTH_MODE_FLUID = 8'hA2;
	localparam logic [7:0] SYNTH_MODE_MUNT  = 8'hA1;
	localparam logic [3:0] INFO_UNKNOWN     = 4'd12;

	//////////////////////////////////////////////////////////////////////
	// Bus types
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic       sys_ce;
		logic       mpu_cep;
		logic       mpu_cen;
		logic       snd_ce;
		logic [1:0] opm_ce;
	} clk_en_t;

	// fd_sync is passed on to the core untouched
	typedef struct packed {
		logic       reset_req;
		logic       nmi;
		logic       power;
		logic       turbo;
		logic [1:0] fd_eject;
		logic [1:0] fd_sync;
	} menu_cmd_t;

	typedef struct packed {
		logic [3:0] mounted;
		logic [1:0] fd_eject;
	} media_state_t;

	typedef struct packed {
		logic download;
		logic wr;
	} loader_req_t;

	typedef struct packed {
		logic aen;
		logic wr;
		logic done;
	} loader_ctl_t;

	typedef struct packed {
		logic       available;
		logic       newmode;
		logic       disabled;
		logic [1:0] info_mode;
		logic [7:0] mode;
		logic [1:0] rom;
		logic [2:0] sf;
	} synth_status_t;

	typedef struct packed {
		logic [15:0] left;
		logic [15:0] right;
	} stereo_t;

endpackage
